/* tb.f */
hdl/uart_mailbox_pkg.sv
hdl/sync_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_mailbox_ctrl.sv
hdl/uart_mailbox_top.sv
bench/tb_uart_mailbox.sv

/* Makefile */
# Verilator build and run for the mailbox UART testbench
SIM       = verilator
SIM_FLAGS = --binary --timing -j 0
TOP       = tb_uart_mailbox
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/tb_uart_mailbox.sv */
// ##############################
// Host writes are applied by the memory model after the rising edge
// Serial line is looped back or driven by a frame generator
// Frame checker follows the divider and parity last set by the host
// ##############################
module tb_uart_mailbox;

localparam int WAIT_CYCLES = 6000;
localparam int MEM_WORDS   = 2 ** uart_mailbox_pkg::ADDR_WIDTH;
localparam int BURST       = uart_mailbox_pkg::FIFO_DEPTH + 6;

logic                                    clk_i = 1'b0;
logic                                    arstn_i;
logic                                    uart_rx_i;
logic                                    uart_tx_o;
logic [uart_mailbox_pkg::MEM_WIDTH-1:0]  mem_rdata_i = '0;
logic [uart_mailbox_pkg::ADDR_WIDTH-1:0] mem_addr_o;
logic [uart_mailbox_pkg::MEM_WIDTH-1:0]  mem_wdata_o;
logic [uart_mailbox_pkg::BYTE_NUM-1:0]   mem_we_o;

logic [uart_mailbox_pkg::MEM_WIDTH-1:0]  mem [MEM_WORDS] = '{default: '0};
logic [uart_mailbox_pkg::ADDR_WIDTH-1:0] port_addr;
logic [uart_mailbox_pkg::BYTE_NUM-1:0]   port_we;
logic [uart_mailbox_pkg::MEM_WIDTH-1:0]  port_wdata;
logic                                    host_we;
logic [uart_mailbox_pkg::ADDR_WIDTH-1:0] host_addr;
logic [uart_mailbox_pkg::MEM_WIDTH-1:0]  host_data;

logic                                    loopback;
logic                                    line_drv;
logic                                    line_prev = 1'b1;
logic                                    mon_busy = 1'b0;
logic [uart_mailbox_pkg::DIV_WIDTH-1:0]  cur_div;
logic                                    cur_par_en;
logic                                    cur_par_odd;
logic [7:0]                              sent_buf [256];
int                                      sent_count;
int                                      checked_count = 0;
int                                      full_cycles = 0;
int                                      seed;
int                                      errors;
int                                      mon_errors = 0;
int                                      tests_run;
int                                      tests_failed;
int                                      test_err_start;

assign uart_rx_i = loopback ? uart_tx_o : line_drv;

uart_mailbox_top u_dut (
    .clk_i       (clk_i      ),
    .arstn_i     (arstn_i    ),
    .uart_rx_i   (uart_rx_i  ),
    .uart_tx_o   (uart_tx_o  ),
    .mem_rdata_i (mem_rdata_i),
    .mem_addr_o  (mem_addr_o ),
    .mem_wdata_o (mem_wdata_o),
    .mem_we_o    (mem_we_o   )
);

always #20 clk_i = ~clk_i;

// BRAM model, read returns the old word when the same edge writes it
always @(posedge clk_i) begin
    port_addr  = mem_addr_o;
    port_we    = mem_we_o;
    port_wdata = mem_wdata_o;
    #2;
    mem_rdata_i = mem[port_addr];
    for (int l = 0; l < uart_mailbox_pkg::BYTE_NUM; l++) begin
        if (port_we[l]) begin
            mem[port_addr][8*l +: 8] = port_wdata[8*l +: 8];
        end
    end
    if (host_we) begin
        mem[host_addr] = host_data;
    end
end

always @(negedge clk_i) begin
    if (u_dut.tx_full === 1'b1) begin
        full_cycles++;
    end
end

function automatic logic parity_bit_for(input logic [7:0] value, input logic odd);
    return odd ? ~(^value) : ^value;
endfunction

function automatic logic [31:0] expected_word(input logic [7:0] value, input logic par_en,
                                              input logic inject_err);
    uart_mailbox_pkg::uart_word_u w;
    w = '0;
    w.data.value = value;
    // A corrupted parity bit is only seen when parity is checked
    w.data.perr = par_en & inject_err;
    return w;
endfunction

task automatic decode_frame();
    int         bt;
    logic [7:0] got;
    logic       par;
    bt = int'(cur_div) + 1;
    mon_busy = 1'b1;
    repeat (bt / 2) @(negedge clk_i);
    if (uart_tx_o !== 1'b0) begin
        $display("start bit on uart_tx_o went high before mid-bit at %0t", $time);
        mon_errors++;
    end
    for (int i = 0; i < 8; i++) begin
        repeat (bt) @(negedge clk_i);
        got[i] = uart_tx_o;
    end
    if (cur_par_en) begin
        repeat (bt) @(negedge clk_i);
        par = uart_tx_o;
        if (par !== parity_bit_for(got, cur_par_odd)) begin
            $display("mismatch at %0t: uart_tx_o parity expected %b, got %b",
                     $time, parity_bit_for(got, cur_par_odd), par);
            mon_errors++;
        end
    end
    repeat (bt) @(negedge clk_i);
    if (uart_tx_o !== 1'b1) begin
        $display("stop bit on uart_tx_o is low at %0t", $time);
        mon_errors++;
    end
    if (checked_count >= sent_count) begin
        $display("frame with byte %h seen on uart_tx_o but no byte was sent", got);
        mon_errors++;
    end else begin
        if (got !== sent_buf[checked_count]) begin
            $display("mismatch at %0t: uart_tx_o byte expected %h, got %h",
                     $time, sent_buf[checked_count], got);
            mon_errors++;
        end
        checked_count++;
    end
    mon_busy = 1'b0;
endtask

// Frame checker, one decode per falling edge of the line
always begin
    @(negedge clk_i);
    if (arstn_i === 1'b1 && line_prev && uart_tx_o === 1'b0) begin
        decode_frame();
    end
    line_prev = uart_tx_o;
end

task automatic write_word(input logic [3:0] addr, input logic [31:0] data);
    @(negedge clk_i);
    host_addr = addr;
    host_data = data;
    host_we   = 1'b1;
    @(negedge clk_i);
    host_we   = 1'b0;
endtask

task automatic wait_ack(input int limit);
    int n;
    n = 0;
    while (mem[uart_mailbox_pkg::CMD_ADDR] != uart_mailbox_pkg::CMD_NONE && n < limit) begin
        @(negedge clk_i);
        n++;
    end
    if (mem[uart_mailbox_pkg::CMD_ADDR] != uart_mailbox_pkg::CMD_NONE) begin
        $display("timeout: command %0h not acknowledged after %0d cycles",
                 mem[uart_mailbox_pkg::CMD_ADDR], limit);
        errors++;
    end
endtask

task automatic wait_tx_idle(input int limit);
    int n;
    n = 0;
    while ((checked_count != sent_count || mon_busy) && n < limit) begin
        @(negedge clk_i);
        n++;
    end
    if (checked_count != sent_count || mon_busy) begin
        $display("timeout: %0d sent bytes never appeared on uart_tx_o",
                 sent_count - checked_count);
        errors++;
    end
endtask

task automatic write_data(input logic [7:0] value);
    uart_mailbox_pkg::uart_word_u w;
    w = '0;
    w.data.value = value;
    write_word(uart_mailbox_pkg::TX_ADDR, w);
    sent_buf[sent_count] = value;
    sent_count++;
endtask

task automatic send_byte(input logic [7:0] value);
    write_data(value);
    write_word(uart_mailbox_pkg::CMD_ADDR, uart_mailbox_pkg::CMD_TX);
    wait_ack(WAIT_CYCLES);
endtask

task automatic set_divider(input logic [uart_mailbox_pkg::DIV_WIDTH-1:0] div);
    write_word(uart_mailbox_pkg::DIV_ADDR, 32'(div));
    write_word(uart_mailbox_pkg::CMD_ADDR, uart_mailbox_pkg::CMD_DIVIDER);
    wait_ack(WAIT_CYCLES);
    cur_div = div;
endtask

task automatic set_control(input logic tx_fl, input logic rx_fl, input logic par_en,
                           input logic par_odd);
    uart_mailbox_pkg::uart_word_u w;
    w = '0;
    w.ctrl.tx_flush   = tx_fl;
    w.ctrl.rx_flush   = rx_fl;
    w.ctrl.parity_en  = par_en;
    w.ctrl.parity_odd = par_odd;
    write_word(uart_mailbox_pkg::CTRL_ADDR, w);
    write_word(uart_mailbox_pkg::CMD_ADDR, uart_mailbox_pkg::CMD_CONTROL);
    wait_ack(WAIT_CYCLES);
    cur_par_en  = par_en;
    cur_par_odd = par_odd;
endtask

task automatic receive_check(input logic [31:0] want);
    // Upper bits set, so a missing write-back cannot pass
    write_word(uart_mailbox_pkg::RX_ADDR, 32'hffff_ffff);
    write_word(uart_mailbox_pkg::CMD_ADDR, uart_mailbox_pkg::CMD_RX);
    wait_ack(WAIT_CYCLES);
    if (mem[uart_mailbox_pkg::RX_ADDR] !== want) begin
        $display("mismatch at %0t: RX_ADDR word expected %h, got %h",
                 $time, want, mem[uart_mailbox_pkg::RX_ADDR]);
        errors++;
    end
endtask

task automatic send_frame(input logic [7:0] value, input logic flip_parity);
    logic [10:0] bits;
    int          nbits;
    bits  = {1'b1, parity_bit_for(value, cur_par_odd) ^ flip_parity, value, 1'b0};
    nbits = cur_par_en ? 11 : 10;
    if (!cur_par_en) begin
        bits[9] = 1'b1;
    end
    @(posedge clk_i);
    #2;
    for (int i = 0; i < nbits; i++) begin
        line_drv = bits[i];
        repeat (int'(cur_div) + 1) @(posedge clk_i);
        #2;
    end
    line_drv = 1'b1;
endtask

task automatic drive_loopback(input logic on);
    @(posedge clk_i);
    #2;
    loopback = on;
endtask

task automatic start_test();
    test_err_start = errors + mon_errors;
    tests_run++;
endtask

task automatic finish_test(input string name);
    if (errors + mon_errors == test_err_start) begin
        $display("test %0d %s: passed", tests_run, name);
    end else begin
        tests_failed++;
        $display("test %0d %s: failed with %0d errors", tests_run, name,
                 errors + mon_errors - test_err_start);
    end
endtask

initial begin
    logic [31:0] rnd;
    logic [7:0]  value;
    logic [7:0]  first;
    int          n;
    int          full_before;
    arstn_i      = 1'b0;
    loopback     = 1'b0;
    line_drv     = 1'b1;
    host_we      = 1'b0;
    host_addr    = '0;
    host_data    = '0;
    cur_div      = uart_mailbox_pkg::DIV_RESET;
    cur_par_en   = 1'b0;
    cur_par_odd  = 1'b0;
    sent_count   = 0;
    seed         = 32'h9a13_b047;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (5) @(posedge clk_i);
    #2;
    arstn_i = 1'b1;

    start_test();
    @(negedge clk_i);
    if (uart_tx_o !== 1'b1) begin
        $display("mismatch at %0t: uart_tx_o expected 1, got %b", $time, uart_tx_o);
        errors++;
    end
    if (mem_we_o !== '0) begin
        $display("mismatch at %0t: mem_we_o expected 0, got %h", $time, mem_we_o);
        errors++;
    end
    set_divider(16'd7);
    finish_test("reset state and divider");

    // Start bit of 8'ha5 is followed by a one, so its width is exact
    start_test();
    write_data(8'ha5);
    write_word(uart_mailbox_pkg::CMD_ADDR, uart_mailbox_pkg::CMD_TX);
    n = 0;
    while (uart_tx_o !== 1'b0 && n < WAIT_CYCLES) begin
        @(negedge clk_i);
        n++;
    end
    if (uart_tx_o !== 1'b0) begin
        $display("timeout: no start bit on uart_tx_o after CMD_TX");
        errors++;
    end else begin
        n = 0;
        while (uart_tx_o === 1'b0 && n < WAIT_CYCLES) begin
            n++;
            @(negedge clk_i);
        end
        if (n != int'(cur_div) + 1) begin
            $display("mismatch at %0t: uart_tx_o start bit clocks expected %0d, got %0d",
                     $time, int'(cur_div) + 1, n);
            errors++;
        end
    end
    wait_ack(WAIT_CYCLES);
    wait_tx_idle(WAIT_CYCLES);
    finish_test("single frame without parity");

    start_test();
    drive_loopback(1'b1);
    set_control(1'b0, 1'b0, 1'b1, 1'b1);
    for (int i = 0; i < 8; i++) begin
        rnd   = $random(seed);
        value = rnd[7:0];
        send_byte(value);
        receive_check(expected_word(value, cur_par_en, 1'b0));
    end
    wait_tx_idle(WAIT_CYCLES);
    finish_test("loopback with odd parity");

    // First frame has a flipped parity bit, the second is clean
    start_test();
    drive_loopback(1'b0);
    set_control(1'b0, 1'b0, 1'b1, 1'b0);
    for (int i = 0; i < 2; i++) begin
        rnd   = $random(seed);
        value = rnd[7:0];
        send_frame(value, i == 0);
        receive_check(expected_word(value, cur_par_en, i == 0));
    end
    finish_test("parity error flag");

    start_test();
    full_before = full_cycles;
    for (int i = 0; i < BURST; i++) begin
        rnd   = $random(seed);
        value = rnd[7:0];
        send_byte(value);
    end
    wait_tx_idle(BURST * 12 * (int'(cur_div) + 1) + WAIT_CYCLES);
    if (full_cycles == full_before) begin
        $display("TX FIFO never reported full, so the burst did not stall the controller");
        errors++;
    end
    finish_test("TX burst with back-pressure");

    start_test();
    drive_loopback(1'b1);
    rnd   = $random(seed);
    first = rnd[7:0];
    send_byte(first);
    wait_tx_idle(WAIT_CYCLES);
    repeat (2 * (int'(cur_div) + 1)) @(negedge clk_i);
    if (u_dut.rx_valid !== 1'b1) begin
        $display("looped byte %h never reached the RX FIFO", first);
        errors++;
    end
    set_control(1'b0, 1'b1, cur_par_en, cur_par_odd);
    set_control(1'b0, 1'b0, cur_par_en, cur_par_odd);
    if (u_dut.rx_valid !== 1'b0) begin
        $display("RX FIFO still holds data after rx_flush");
        errors++;
    end
    send_byte(~first);
    receive_check(expected_word(~first, cur_par_en, 1'b0));
    wait_tx_idle(WAIT_CYCLES);
    finish_test("RX flush");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
             errors + mon_errors);
    if (errors + mon_errors == 0) begin
        $display("PASS: all tests");
    end else begin
        $display("FAIL: see errors above");
    end
    $finish;
end

endmodule

/* hdl/uart_mailbox_top.sv */
// ############################
// Mailbox UART, the memory itself sits outside this block
// ############################
module uart_mailbox_top (
    input  logic                                  clk_i,
    input  logic                                  arstn_i,
    input  logic                                  uart_rx_i,
    output logic                                  uart_tx_o,
    input  logic [uart_mailbox_pkg::MEM_WIDTH-1:0]  mem_rdata_i,
    output logic [uart_mailbox_pkg::ADDR_WIDTH-1:0] mem_addr_o,
    output logic [uart_mailbox_pkg::MEM_WIDTH-1:0]  mem_wdata_o,
    output logic [uart_mailbox_pkg::BYTE_NUM-1:0]   mem_we_o
);

logic                                   tx_push;
logic [uart_mailbox_pkg::DATA_WIDTH-1:0] tx_byte;
logic                                   tx_full;
logic                                   tx_valid;
logic                                   tx_ready;
logic [uart_mailbox_pkg::DATA_WIDTH:0]   tx_fifo_data;
logic                                   rx_strobe;
logic [uart_mailbox_pkg::DATA_WIDTH:0]   rx_word;
logic                                   rx_valid;
logic                                   rx_ready;
logic [uart_mailbox_pkg::DATA_WIDTH:0]   rx_fifo_data;
logic [uart_mailbox_pkg::DIV_WIDTH-1:0]  divider;
logic                                   parity_en;
logic                                   parity_odd;
logic                                   tx_flush;
logic                                   rx_flush;

uart_mailbox_ctrl u_ctrl (
    .clk_i        (clk_i       ),
    .arstn_i      (arstn_i     ),
    .mem_rdata_i  (mem_rdata_i ),
    .mem_addr_o   (mem_addr_o  ),
    .mem_wdata_o  (mem_wdata_o ),
    .mem_we_o     (mem_we_o    ),
    .tx_full_i    (tx_full     ),
    .tx_push_o    (tx_push     ),
    .tx_byte_o    (tx_byte     ),
    .rx_valid_i   (rx_valid    ),
    .rx_data_i    (rx_fifo_data),
    .rx_ready_o   (rx_ready    ),
    .divider_o    (divider     ),
    .parity_en_o  (parity_en   ),
    .parity_odd_o (parity_odd  ),
    .tx_flush_o   (tx_flush    ),
    .rx_flush_o   (rx_flush    )
);

// TX stores no error flag, the top bit stays zero
sync_fifo u_tx_fifo (
    .clk_i      (clk_i          ),
    .arstn_i    (arstn_i        ),
    .flush_i    (tx_flush       ),
    .wr_en_i    (tx_push        ),
    .wr_data_i  ({1'b0, tx_byte}),
    .rd_ready_i (tx_ready       ),
    .full_o     (tx_full        ),
    .rd_valid_o (tx_valid       ),
    .rd_data_o  (tx_fifo_data   )
);

uart_tx u_uart_tx (
    .clk_i        (clk_i                                          ),
    .arstn_i      (arstn_i                                        ),
    .flush_i      (tx_flush                                       ),
    .divider_i    (divider                                        ),
    .parity_en_i  (parity_en                                      ),
    .parity_odd_i (parity_odd                                     ),
    .s_valid_i    (tx_valid                                       ),
    .s_data_i     (tx_fifo_data[uart_mailbox_pkg::DATA_WIDTH-1:0]),
    .s_ready_o    (tx_ready                                       ),
    .uart_tx_o    (uart_tx_o                                      )
);

uart_rx u_uart_rx (
    .clk_i        (clk_i     ),
    .arstn_i      (arstn_i   ),
    .flush_i      (rx_flush  ),
    .divider_i    (divider   ),
    .parity_en_i  (parity_en ),
    .parity_odd_i (parity_odd),
    .uart_rx_i    (uart_rx_i ),
    .m_valid_o    (rx_strobe ),
    .m_data_o     (rx_word   )
);

// A byte arriving while full is lost
sync_fifo u_rx_fifo (
    .clk_i      (clk_i       ),
    .arstn_i    (arstn_i     ),
    .flush_i    (rx_flush    ),
    .wr_en_i    (rx_strobe   ),
    .wr_data_i  (rx_word     ),
    .rd_ready_i (rx_ready    ),
    .full_o     (            ),
    .rd_valid_o (rx_valid    ),
    .rd_data_o  (rx_fifo_data)
);

endmodule

/* hdl/uart_mailbox_ctrl.sv */
// ############################
// Polls the command word, acknowledges by writing it to zero
// Host must write operands before the command
// RX command blocks until a byte arrives
// ############################
module uart_mailbox_ctrl (
    input  logic                                  clk_i,
    input  logic                                  arstn_i,
    input  logic [uart_mailbox_pkg::MEM_WIDTH-1:0]  mem_rdata_i,
    output logic [uart_mailbox_pkg::ADDR_WIDTH-1:0] mem_addr_o,
    output logic [uart_mailbox_pkg::MEM_WIDTH-1:0]  mem_wdata_o,
    output logic [uart_mailbox_pkg::BYTE_NUM-1:0]   mem_we_o,
    input  logic                                  tx_full_i,
    output logic                                  tx_push_o,
    output logic [uart_mailbox_pkg::DATA_WIDTH-1:0] tx_byte_o,
    input  logic                                  rx_valid_i,
    input  logic [uart_mailbox_pkg::DATA_WIDTH:0]   rx_data_i,
    output logic                                  rx_ready_o,
    output logic [uart_mailbox_pkg::DIV_WIDTH-1:0]  divider_o,
    output logic                                  parity_en_o,
    output logic                                  parity_odd_o,
    output logic                                  tx_flush_o,
    output logic                                  rx_flush_o
);

typedef enum logic [2:0] {
    ST_IDLE,
    ST_READ,
    ST_RX_WAIT,
    ST_RX_WB,
    ST_ACK
} state_e;

state_e                       state;
logic [1:0]                   cnt;
logic                         poll_ok;
logic                         operand_ok;
uart_mailbox_pkg::uart_word_u rd_word;
uart_mailbox_pkg::uart_word_u rx_word_q;

assign rd_word    = mem_rdata_i;
assign operand_ok = (state == ST_READ) && (cnt == 2'd2);

// Operand address is held while stalled, so the byte stays on the read port
assign tx_push_o = operand_ok && (mem_addr_o == uart_mailbox_pkg::TX_ADDR) && !tx_full_i;
assign tx_byte_o = rd_word.data.value;

assign rx_ready_o  = (state == ST_RX_WAIT);
assign mem_wdata_o = (state == ST_RX_WB) ? rx_word_q : '0;

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
        state        <= ST_IDLE;
        cnt          <= '0;
        poll_ok      <= 1'b0;
        mem_addr_o   <= uart_mailbox_pkg::CMD_ADDR;
        mem_we_o     <= '0;
        divider_o    <= uart_mailbox_pkg::DIV_RESET;
        parity_en_o  <= 1'b0;
        parity_odd_o <= 1'b0;
        tx_flush_o   <= 1'b0;
        rx_flush_o   <= 1'b0;
    end else begin
        // Read data is stale for a cycle after the acknowledge write
        poll_ok <= (state == ST_IDLE) && (mem_we_o == '0);
        case (state)
            ST_IDLE: begin
                cnt <= '0;
                if (poll_ok && mem_rdata_i != uart_mailbox_pkg::CMD_NONE) begin
                    state <= ST_READ;
                    case (mem_rdata_i)
                        uart_mailbox_pkg::CMD_DIVIDER: mem_addr_o <= uart_mailbox_pkg::DIV_ADDR;
                        uart_mailbox_pkg::CMD_CONTROL: mem_addr_o <= uart_mailbox_pkg::CTRL_ADDR;
                        uart_mailbox_pkg::CMD_TX:      mem_addr_o <= uart_mailbox_pkg::TX_ADDR;
                        uart_mailbox_pkg::CMD_RX:      state <= ST_RX_WAIT;
                        default: begin
                            mem_we_o <= '1;
                            state    <= ST_ACK;
                        end
                    endcase
                end
            end
            ST_READ: begin
                // The operand address also tells which command is running
                if (cnt != 2'd2) begin
                    cnt <= cnt + 1'b1;
                end else if (mem_addr_o != uart_mailbox_pkg::TX_ADDR || !tx_full_i) begin
                    if (mem_addr_o == uart_mailbox_pkg::DIV_ADDR) begin
                        divider_o <= mem_rdata_i[uart_mailbox_pkg::DIV_WIDTH-1:0];
                    end
                    if (mem_addr_o == uart_mailbox_pkg::CTRL_ADDR) begin
                        tx_flush_o   <= rd_word.ctrl.tx_flush;
                        rx_flush_o   <= rd_word.ctrl.rx_flush;
                        parity_en_o  <= rd_word.ctrl.parity_en;
                        parity_odd_o <= rd_word.ctrl.parity_odd;
                    end
                    mem_addr_o <= uart_mailbox_pkg::CMD_ADDR;
                    mem_we_o   <= '1;
                    state      <= ST_ACK;
                end
            end
            ST_RX_WAIT: begin
                if (rx_valid_i) begin
                    mem_addr_o <= uart_mailbox_pkg::RX_ADDR;
                    mem_we_o   <= '1;
                    state      <= ST_RX_WB;
                end
            end
            ST_RX_WB: begin
                mem_addr_o <= uart_mailbox_pkg::CMD_ADDR;
                state      <= ST_ACK;
            end
            ST_ACK: begin
                mem_we_o <= '0;
                state    <= ST_IDLE;
            end
            default: state <= ST_IDLE;
        endcase
    end
end

// Result word for the RX write-back
always_ff @(posedge clk_i) begin
    if (rx_ready_o && rx_valid_i) begin
        rx_word_q.data.zero  <= '0;
        rx_word_q.data.perr  <= rx_data_i[uart_mailbox_pkg::DATA_WIDTH];
        rx_word_q.data.value <= rx_data_i[uart_mailbox_pkg::DATA_WIDTH-1:0];
    end
end

endmodule

/* hdl/uart_rx.sv */
// ############################
// Receiver samples mid-bit, one stop bit only
// Error flag covers bad parity and a low stop bit
// ############################
module uart_rx (
    input  logic                                 clk_i,
    input  logic                                 arstn_i,
    input  logic                                 flush_i,
    input  logic [uart_mailbox_pkg::DIV_WIDTH-1:0] divider_i,
    input  logic                                 parity_en_i,
    input  logic                                 parity_odd_i,
    input  logic                                 uart_rx_i,
    output logic                                 m_valid_o,
    output logic [uart_mailbox_pkg::DATA_WIDTH:0]  m_data_o
);

typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
} state_e;

state_e                                  state;
logic [2:0]                              rx_sync;
logic                                    rx_bit;
logic [uart_mailbox_pkg::DIV_WIDTH-1:0]  baud_cnt;
logic                                    baud_tick;
logic                                    half_tick;
logic [2:0]                              bit_idx;
logic [uart_mailbox_pkg::DATA_WIDTH-1:0] shift_q;
logic                                    perr_q;

// Two synchronizer flops, the third keeps the previous level for edge detect
always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
        rx_sync <= '1;
    end else begin
        rx_sync <= {rx_sync[1:0], uart_rx_i};
    end
end

assign rx_bit    = rx_sync[1];
assign baud_tick = (baud_cnt == divider_i);
assign half_tick = (baud_cnt == (divider_i >> 1));

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
        state     <= RX_IDLE;
        baud_cnt  <= '0;
        bit_idx   <= '0;
        m_valid_o <= 1'b0;
    end else if (flush_i) begin
        state     <= RX_IDLE;
        m_valid_o <= 1'b0;
    end else begin
        m_valid_o <= 1'b0;
        baud_cnt  <= baud_cnt + 1'b1;
        case (state)
            RX_IDLE: begin
                baud_cnt <= '0;
                if (rx_sync[2] && !rx_bit) begin
                    state <= RX_START;
                end
            end
            RX_START: begin
                // A start bit gone high by mid-bit was a glitch
                if (half_tick) begin
                    baud_cnt <= '0;
                    bit_idx  <= '0;
                    state    <= rx_bit ? RX_IDLE : RX_DATA;
                end
            end
            RX_DATA: begin
                if (baud_tick) begin
                    baud_cnt <= '0;
                    bit_idx  <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) begin
                        state <= parity_en_i ? RX_PARITY : RX_STOP;
                    end
                end
            end
            RX_PARITY: begin
                if (baud_tick) begin
                    baud_cnt <= '0;
                    state    <= RX_STOP;
                end
            end
            RX_STOP: begin
                if (baud_tick) begin
                    m_valid_o <= 1'b1;
                    state     <= RX_IDLE;
                end
            end
            default: state <= RX_IDLE;
        endcase
    end
end

always_ff @(posedge clk_i) begin
    if (state == RX_START) begin
        perr_q <= 1'b0;
    end else if (baud_tick && state == RX_PARITY) begin
        perr_q <= (rx_bit != (^shift_q ^ parity_odd_i));
    end
    if (baud_tick && state == RX_DATA) begin
        shift_q <= {rx_bit, shift_q[uart_mailbox_pkg::DATA_WIDTH-1:1]};
    end
    if (baud_tick && state == RX_STOP) begin
        m_data_o <= {perr_q | ~rx_bit, shift_q};
    end
end

endmodule

/* hdl/uart_tx.sv */
// ############################
// 8-N-1 or 8-P-1 transmitter, each bit lasts divider+1 clocks
// Flush aborts a frame in flight
// ############################
module uart_tx (
    input  logic                                  clk_i,
    input  logic                                  arstn_i,
    input  logic                                  flush_i,
    input  logic [uart_mailbox_pkg::DIV_WIDTH-1:0]  divider_i,
    input  logic                                  parity_en_i,
    input  logic                                  parity_odd_i,
    input  logic                                  s_valid_i,
    input  logic [uart_mailbox_pkg::DATA_WIDTH-1:0] s_data_i,
    output logic                                  s_ready_o,
    output logic                                  uart_tx_o
);

logic                                   busy;
logic [uart_mailbox_pkg::DIV_WIDTH-1:0] baud_cnt;
logic [3:0]                             bits_left;
logic [uart_mailbox_pkg::DATA_WIDTH+2:0] shift_q;
logic                                   parity_bit;

assign s_ready_o = ~busy;

// Ones are shifted in behind the frame, so the line idles high
assign uart_tx_o = shift_q[0];

// Without parity this slot carries the stop bit
assign parity_bit = parity_en_i ? (^s_data_i ^ parity_odd_i) : 1'b1;

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
        busy      <= 1'b0;
        baud_cnt  <= '0;
        bits_left <= '0;
        shift_q   <= '1;
    end else if (flush_i) begin
        busy      <= 1'b0;
        baud_cnt  <= '0;
        shift_q   <= '1;
    end else if (!busy) begin
        baud_cnt <= '0;
        if (s_valid_i) begin
            busy      <= 1'b1;
            shift_q   <= {1'b1, parity_bit, s_data_i, 1'b0};
            bits_left <= parity_en_i ? 4'd11 : 4'd10;
        end
    end else if (baud_cnt == divider_i) begin
        baud_cnt  <= '0;
        shift_q   <= {1'b1, shift_q[uart_mailbox_pkg::DATA_WIDTH+2:1]};
        bits_left <= bits_left - 1'b1;
        if (bits_left == 4'd1) begin
            busy <= 1'b0;
        end
    end else begin
        baud_cnt <= baud_cnt + 1'b1;
    end
end

endmodule

/* hdl/sync_fifo.sv */
// ############################
// First-word-fall-through FIFO, depth must be a power of two
// Writes while full or flushing are dropped
// ############################
module sync_fifo (
    input  logic                                clk_i,
    input  logic                                arstn_i,
    input  logic                                flush_i,
    input  logic                                wr_en_i,
    input  logic [uart_mailbox_pkg::DATA_WIDTH:0] wr_data_i,
    input  logic                                rd_ready_i,
    output logic                                full_o,
    output logic                                rd_valid_o,
    output logic [uart_mailbox_pkg::DATA_WIDTH:0] rd_data_o
);

localparam int DEPTH = uart_mailbox_pkg::FIFO_DEPTH;
localparam int PTR_W = $clog2(DEPTH);

logic [uart_mailbox_pkg::DATA_WIDTH:0] mem [DEPTH];
logic [PTR_W-1:0]                      wr_ptr;
logic [PTR_W-1:0]                      rd_ptr;
logic [PTR_W:0]                        count;
logic                                  do_wr;
logic                                  do_rd;

assign full_o     = (count == (PTR_W+1)'(DEPTH));
assign rd_valid_o = (count != '0);
assign rd_data_o  = mem[rd_ptr];

assign do_wr = wr_en_i & ~full_o & ~flush_i;
assign do_rd = rd_ready_i & rd_valid_o & ~flush_i;

always_ff @(posedge clk_i) begin
    if (do_wr) begin
        mem[wr_ptr] <= wr_data_i;
    end
end

always_ff @(posedge clk_i or negedge arstn_i) begin
    if (!arstn_i) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else if (flush_i) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        // Pointers wrap on their own
        if (do_wr && !do_rd) begin
            count <= count + 1'b1;
        end else if (do_rd && !do_wr) begin
            count <= count - 1'b1;
        end
    end
end

endmodule

/* hdl/uart_mailbox_pkg.sv */
// ############################
// Mailbox addresses are word indices, commands are whole words
// Control and data views share one word through a packed union
// ############################
package uart_mailbox_pkg;

localparam int MEM_WIDTH  = 32;
localparam int ADDR_WIDTH = 4;
localparam int BYTE_NUM   = 4;
localparam int DATA_WIDTH = 8;
localparam int FIFO_DEPTH = 16;
localparam int DIV_WIDTH  = 16;

localparam logic [ADDR_WIDTH-1:0] CMD_ADDR  = 4'd0;
localparam logic [ADDR_WIDTH-1:0] DIV_ADDR  = 4'd1;
localparam logic [ADDR_WIDTH-1:0] CTRL_ADDR = 4'd2;
localparam logic [ADDR_WIDTH-1:0] TX_ADDR   = 4'd3;
localparam logic [ADDR_WIDTH-1:0] RX_ADDR   = 4'd4;

localparam logic [MEM_WIDTH-1:0] CMD_NONE    = 32'd0;
localparam logic [MEM_WIDTH-1:0] CMD_DIVIDER = 32'd1;
localparam logic [MEM_WIDTH-1:0] CMD_CONTROL = 32'd2;
localparam logic [MEM_WIDTH-1:0] CMD_TX      = 32'd3;
localparam logic [MEM_WIDTH-1:0] CMD_RX      = 32'd4;

localparam logic [DIV_WIDTH-1:0] DIV_RESET = 16'd16;

typedef struct packed {
    logic [MEM_WIDTH-5:0] reserved;
    logic                 parity_odd;
    logic                 parity_en;
    logic                 rx_flush;
    logic                 tx_flush;
} ctrl_word_t;

// Parity error sits just above the byte
typedef struct packed {
    logic [MEM_WIDTH-DATA_WIDTH-2:0] zero;
    logic                            perr;
    logic [DATA_WIDTH-1:0]           value;
} data_word_t;

typedef union packed {
    ctrl_word_t ctrl;
    data_word_t data;
} uart_word_u;

endpackage
